// File: ddr_wbuf_pkg.sv
//******************************
// shared types and default sizes
// for the ddr3 write-data buffer
//******************************

package ddr_wbuf_pkg;

    //******************************
    // burst reader states
    //******************************
    typedef enum logic
    {
        ST_IDLE  = 1'b0,  // waiting for data or flush
        ST_BURST = 1'b1   // issuing read strobes
    } burst_state_t;

    //******************************
    // default sizes
    //******************************

    // address width, 16 entries
    localparam int DEF_DEPTH_WIDTH = 4;

    // one word per beat
    localparam int DEF_DATA_WIDTH = 32;

    // beats per full burst
    // must not exceed the fifo depth
    localparam int DEF_BURST_LEN = 4;

endpackage

// File: fifo_mem_if.sv
`timescale 1ns/1ps
//******************************
// strobes and addresses from fifo
// controller to storage array
//******************************

interface fifo_mem_if
    import ddr_wbuf_pkg::*;
#(
    parameter int DEPTH_WIDTH = DEF_DEPTH_WIDTH
)
();

    logic                   we;     // accepted write only
    logic [DEPTH_WIDTH-1:0] waddr;  // current write pointer, low bits
    logic                   re;     // accepted read only
    logic [DEPTH_WIDTH-1:0] raddr;  // current read pointer, low bits

    // controller side
    modport ctrl
    (
        output we, waddr, re, raddr
    );

    // array side
    modport mem
    (
        input we, waddr, re, raddr
    );

endinterface

// File: wbuf_fifo_ctrl.sv
`timescale 1ns/1ps
//******************************
// single clock fifo controller: pointers, full/empty,
// fill levels, almost-full and almost-empty thresholds
//******************************

module wbuf_fifo_ctrl
    import ddr_wbuf_pkg::*;
#(
    parameter int DEPTH_WIDTH      = DEF_DEPTH_WIDTH,
    parameter int ALMOST_FULL_NUM  = (1 << DEF_DEPTH_WIDTH) - 4,
    parameter int ALMOST_EMPTY_NUM = 2
)
(
    input  logic                 rclk,
    input  logic                 rrst,

    input  logic                 wr_en,         // user write strobe
    output logic                 wfull,
    output logic                 almost_full,
    output logic [DEPTH_WIDTH:0] wr_level,      // words stored, write view

    input  logic                 rd_en,         // from burst reader
    output logic                 rempty,
    output logic                 almost_empty,
    output logic [DEPTH_WIDTH:0] rd_level,      // words stored, read view

    fifo_mem_if.ctrl             mem
);

    localparam int PTR_W = DEPTH_WIDTH + 1;

    // thresholds sized to the level width
    localparam logic [DEPTH_WIDTH:0] AF_LVL = PTR_W'(ALMOST_FULL_NUM);
    localparam logic [DEPTH_WIDTH:0] AE_LVL = PTR_W'(ALMOST_EMPTY_NUM);

    //******************************
    // pointers, one extra wrap bit
    //******************************
    logic [DEPTH_WIDTH:0] wptr;       // current write pointer
    logic [DEPTH_WIDTH:0] wptr_nxt;   // write pointer after this edge
    logic [DEPTH_WIDTH:0] rptr;       // current read pointer
    logic [DEPTH_WIDTH:0] rptr_nxt;   // read pointer after this edge
    logic [DEPTH_WIDTH:0] level_nxt;  // fill after this edge
    logic                 full_nxt;
    logic                 empty_nxt;
    logic                 wr_ok;      // write accepted
    logic                 rd_ok;      // read accepted

    // writes dropped while full, reads ignored while empty
    assign wr_ok = wr_en & ~wfull;
    assign rd_ok = rd_en & ~rempty;

    assign wptr_nxt = wptr + PTR_W'(wr_ok);
    assign rptr_nxt = rptr + PTR_W'(rd_ok);

    // modulo difference covers 0 .. 2**DEPTH_WIDTH
    assign level_nxt = wptr_nxt - rptr_nxt;

    // full: wrap bits differ, low bits match
    assign full_nxt = (wptr_nxt[DEPTH_WIDTH] != rptr_nxt[DEPTH_WIDTH]) &&
                      (wptr_nxt[DEPTH_WIDTH-1:0] == rptr_nxt[DEPTH_WIDTH-1:0]);

    // empty: pointers identical
    assign empty_nxt = (wptr_nxt == rptr_nxt);

    //******************************
    // write side registers
    //******************************
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            wptr     <= '0;
            wfull    <= 1'b0;
            wr_level <= '0;
        end
        else
        begin
            wptr     <= wptr_nxt;
            wfull    <= full_nxt;   // no lag behind the write
            wr_level <= level_nxt;
        end
    end

    //******************************
    // read side registers
    //******************************
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            rptr     <= '0;
            rempty   <= 1'b1;       // starts empty
            rd_level <= '0;
        end
        else
        begin
            rptr     <= rptr_nxt;
            rempty   <= empty_nxt;
            rd_level <= level_nxt;
        end
    end

    //******************************
    // memory strobes
    //******************************

    // addresses from current pointers, strobes only when accepted
    assign mem.we    = wr_ok;
    assign mem.waddr = wptr[DEPTH_WIDTH-1:0];
    assign mem.re    = rd_ok;
    assign mem.raddr = rptr[DEPTH_WIDTH-1:0];

    // threshold flags, straight off the level registers
    assign almost_full  = (wr_level >= AF_LVL);
    assign almost_empty = (rd_level <= AE_LVL);  // high out of reset

endmodule

// File: wbuf_ram.sv
`timescale 1ns/1ps
//******************************
// simple dual-port storage array
// with registered read data
//******************************

module wbuf_ram
    import ddr_wbuf_pkg::*;
#(
    parameter int DEPTH_WIDTH = DEF_DEPTH_WIDTH,
    parameter int DATA_WIDTH  = DEF_DATA_WIDTH
)
(
    input  logic                  rclk,
    input  logic [DATA_WIDTH-1:0] wdata,   // straight from user port
    output logic [DATA_WIDTH-1:0] rdata,   // toward ddr3 write data
    fifo_mem_if.mem               mem
);

    localparam int DEPTH = 1 << DEPTH_WIDTH;

    // storage, contents undefined until written
    logic [DATA_WIDTH-1:0] ram_q [0:DEPTH-1];

    // write port
    always_ff @(posedge rclk)
    begin
        if (mem.we)
            ram_q[mem.waddr] <= wdata;
    end

    // read port, one cycle latency
    // word held between reads
    always_ff @(posedge rclk)
    begin
        if (mem.re)
            rdata <= ram_q[mem.raddr];
    end

endmodule

// File: burst_reader.sv
`timescale 1ns/1ps
//******************************
// burst reader fsm, read strobes
// and first/last beat markers
//******************************

module burst_reader
    import ddr_wbuf_pkg::*;
#(
    parameter int DEPTH_WIDTH = DEF_DEPTH_WIDTH,
    parameter int BURST_LEN   = DEF_BURST_LEN
)
(
    input  logic                 rclk,
    input  logic                 rrst,
    input  logic                 ddr_ready,   // controller takes a whole burst
    input  logic                 flush,       // drain a partial burst
    input  logic                 rempty,
    input  logic [DEPTH_WIDTH:0] rd_level,
    output logic                 rd_en,
    output logic                 ddr_wvalid,
    output logic                 ddr_wfirst,
    output logic                 ddr_wlast
);

    localparam int CNT_W = DEPTH_WIDTH + 1;
    localparam logic [DEPTH_WIDTH:0] BL_LVL = CNT_W'(BURST_LEN);

    burst_state_t         state;
    burst_state_t         state_nxt;
    logic [DEPTH_WIDTH:0] beat_cnt;     // beats issued in this burst
    logic [DEPTH_WIDTH:0] burst_len;    // latched at start
    logic [DEPTH_WIDTH:0] start_len;
    logic                 start;
    logic                 first_beat;
    logic                 last_beat;

    // full burst on threshold, partial one on flush
    assign start     = ddr_ready & ((rd_level >= BL_LVL) | (flush & ~rempty));
    assign start_len = (rd_level >= BL_LVL) ? BL_LVL : rd_level;  // min of the two

    assign first_beat = (beat_cnt == '0);
    assign last_beat  = (beat_cnt == burst_len - CNT_W'(1));

    //******************************
    // state machine
    //******************************
    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
            begin
                if (start)
                    state_nxt = ST_BURST;
            end
            ST_BURST:
            begin
                if (last_beat)
                    state_nxt = ST_IDLE;  // burst always runs to the end
            end
            default:
            begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            state     <= ST_IDLE;
            beat_cnt  <= '0;
            burst_len <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (state == ST_IDLE)
            begin
                beat_cnt <= '0;
                if (start)
                    burst_len <= start_len;
            end
            else
                beat_cnt <= beat_cnt + CNT_W'(1);
        end
    end

    // one read per burst cycle
    assign rd_en = (state == ST_BURST);

    //******************************
    // delay line, lines up with rdata
    //******************************
    always_ff @(posedge rclk or posedge rrst)
    begin
        if (rrst)
        begin
            ddr_wvalid <= 1'b0;
            ddr_wfirst <= 1'b0;
            ddr_wlast  <= 1'b0;
        end
        else
        begin
            ddr_wvalid <= rd_en;
            ddr_wfirst <= rd_en & first_beat;
            ddr_wlast  <= rd_en & last_beat;
        end
    end

endmodule

// File: ddr_wbuf_top.sv
`timescale 1ns/1ps
//******************************
// ddr3 write-data buffer top:
// fifo controller, storage array, burst reader
//******************************

module ddr_wbuf_top
    import ddr_wbuf_pkg::*;
#(
    parameter int DEPTH_WIDTH      = DEF_DEPTH_WIDTH,
    parameter int DATA_WIDTH       = DEF_DATA_WIDTH,
    parameter int BURST_LEN        = DEF_BURST_LEN,
    parameter int ALMOST_FULL_NUM  = 12,
    parameter int ALMOST_EMPTY_NUM = 2
)
(
    input  logic                  rclk,
    input  logic                  rrst,

    // user write port
    input  logic                  wr_en,
    input  logic [DATA_WIDTH-1:0] wr_data,
    output logic                  wfull,
    output logic                  almost_full,
    output logic [DEPTH_WIDTH:0]  wr_level,

    // ddr3 controller side
    input  logic                  ddr_ready,
    input  logic                  flush,
    output logic                  rempty,
    output logic                  almost_empty,
    output logic                  ddr_wvalid,
    output logic [DATA_WIDTH-1:0] ddr_wdata,
    output logic                  ddr_wfirst,
    output logic                  ddr_wlast
);

    logic                 rd_en;     // reader to controller
    logic [DEPTH_WIDTH:0] rd_level;  // controller to reader

    // strobes and addresses, controller to array
    fifo_mem_if #(.DEPTH_WIDTH(DEPTH_WIDTH)) u_mem_if ();

    wbuf_fifo_ctrl #(
        .DEPTH_WIDTH      (DEPTH_WIDTH),
        .ALMOST_FULL_NUM  (ALMOST_FULL_NUM),
        .ALMOST_EMPTY_NUM (ALMOST_EMPTY_NUM)
    ) u_ctrl (
        .rclk         (rclk),
        .rrst         (rrst),
        .wr_en        (wr_en),
        .wfull        (wfull),
        .almost_full  (almost_full),
        .wr_level     (wr_level),
        .rd_en        (rd_en),
        .rempty       (rempty),
        .almost_empty (almost_empty),
        .rd_level     (rd_level),
        .mem          (u_mem_if.ctrl)
    );

    wbuf_ram #(
        .DEPTH_WIDTH (DEPTH_WIDTH),
        .DATA_WIDTH  (DATA_WIDTH)
    ) u_ram (
        .rclk  (rclk),
        .wdata (wr_data),
        .rdata (ddr_wdata),   // valid with ddr_wvalid
        .mem   (u_mem_if.mem)
    );

    burst_reader #(
        .DEPTH_WIDTH (DEPTH_WIDTH),
        .BURST_LEN   (BURST_LEN)
    ) u_rdr (
        .rclk       (rclk),
        .rrst       (rrst),
        .ddr_ready  (ddr_ready),
        .flush      (flush),
        .rempty     (rempty),
        .rd_level   (rd_level),
        .rd_en      (rd_en),
        .ddr_wvalid (ddr_wvalid),
        .ddr_wfirst (ddr_wfirst),
        .ddr_wlast  (ddr_wlast)
    );

endmodule

// File: tb_ddr_wbuf.sv
`timescale 1ns/1ps
//******************************
// testbench for the ddr3 write-data buffer
// reference model, per-cycle compare, six tests
//******************************

module tb_ddr_wbuf;

    localparam int DEPTH_WIDTH      = 4;
    localparam int DATA_WIDTH       = 32;
    localparam int BURST_LEN        = 4;
    localparam int ALMOST_FULL_NUM  = 12;
    localparam int ALMOST_EMPTY_NUM = 2;
    localparam int DEPTH            = 1 << DEPTH_WIDTH;
    localparam int TIMEOUT_CYC      = 6 * 200 + 16;  // six tests plus reset

    logic                  rclk;
    logic                  rrst;
    logic                  wr_en;
    logic [DATA_WIDTH-1:0] wr_data;
    logic                  ddr_ready;
    logic                  flush;
    logic                  wfull;
    logic                  almost_full;
    logic [DEPTH_WIDTH:0]  wr_level;
    logic                  rempty;
    logic                  almost_empty;
    logic                  ddr_wvalid;
    logic [DATA_WIDTH-1:0] ddr_wdata;
    logic                  ddr_wfirst;
    logic                  ddr_wlast;

    // reference model state as of the last rising edge
    logic [DATA_WIDTH-1:0] exp_q [$];   // accepted words in write order
    int                    exp_cnt;     // words stored
    int                    rd_rem;      // beats left in current burst
    int                    beat_idx;
    logic                  exp_valid;
    logic [DATA_WIDTH-1:0] exp_data;
    logic                  exp_first;
    logic                  exp_last;
    logic                  rd_now;
    logic                  wr_now;
    logic [3:0]            flags;

    string cur_test;
    int    err_cnt;
    int    err_at_start;
    int    check_cnt;
    int    test_cnt;
    int    beat_seen;   // ddr_wvalid beats in this test
    int    last_seen;   // ddr_wlast beats in this test
    int    cycle_cnt;

    ddr_wbuf_top #(
        .DEPTH_WIDTH      (DEPTH_WIDTH),
        .DATA_WIDTH       (DATA_WIDTH),
        .BURST_LEN        (BURST_LEN),
        .ALMOST_FULL_NUM  (ALMOST_FULL_NUM),
        .ALMOST_EMPTY_NUM (ALMOST_EMPTY_NUM)
    ) u_dut (
        .rclk         (rclk),
        .rrst         (rrst),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .wfull        (wfull),
        .almost_full  (almost_full),
        .wr_level     (wr_level),
        .ddr_ready    (ddr_ready),
        .flush        (flush),
        .rempty       (rempty),
        .almost_empty (almost_empty),
        .ddr_wvalid   (ddr_wvalid),
        .ddr_wdata    (ddr_wdata),
        .ddr_wfirst   (ddr_wfirst),
        .ddr_wlast    (ddr_wlast)
    );

    initial
    begin
        rclk = 1'b0;
        forever #10 rclk = ~rclk;  // 20 ns period
    end

    // {wfull, almost_full, rempty, almost_empty} for a fill count
    function automatic logic [3:0] ref_level_flags(input int cnt);
        logic [3:0] f;
        f[3] = (cnt == DEPTH);
        f[2] = (cnt >= ALMOST_FULL_NUM);
        f[1] = (cnt == 0);
        f[0] = (cnt <= ALMOST_EMPTY_NUM);
        return f;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        check_cnt++;
        assert (exp_v == act_v)
        else
        begin
            $display("MISMATCH %s %s expected 0x%0h actual 0x%0h",
                     cur_test, what, exp_v, act_v);
            err_cnt++;
        end
    endtask

    //******************************
    // model and compare at negedge
    //******************************
    always @(negedge rclk)
    begin
        if (rrst)
        begin
            exp_q.delete();
            exp_cnt   = 0;
            rd_rem    = 0;
            beat_idx  = 0;
            exp_valid = 1'b0;
        end
        else
        begin
            flags = ref_level_flags(exp_cnt);
            check_value("wr_level", exp_cnt, 32'(wr_level));
            check_value("wfull", 32'(flags[3]), 32'(wfull));
            check_value("almost_full", 32'(flags[2]), 32'(almost_full));
            check_value("rempty", 32'(flags[1]), 32'(rempty));
            check_value("almost_empty", 32'(flags[0]), 32'(almost_empty));
            check_value("ddr_wvalid", 32'(exp_valid), 32'(ddr_wvalid));
            if (ddr_wvalid !== exp_valid)
                $display("  reader in %s", u_dut.u_rdr.state.name());
            if (exp_valid)
            begin
                check_value("ddr_wdata", exp_data, ddr_wdata);
                check_value("ddr_wfirst", 32'(exp_first), 32'(ddr_wfirst));
                check_value("ddr_wlast", 32'(exp_last), 32'(ddr_wlast));
            end
            if (ddr_wvalid)
                beat_seen++;
            if (ddr_wvalid && ddr_wlast)
                last_seen++;

            // step the model over the coming edge
            rd_now = (rd_rem > 0);
            wr_now = wr_en && (exp_cnt < DEPTH);  // dropped while full
            exp_valid = rd_now;
            if (rd_now)
            begin
                exp_data  = exp_q.pop_front();
                exp_first = (beat_idx == 0);
                exp_last  = (rd_rem == 1);
                rd_rem--;
                beat_idx++;
            end
            else if (ddr_ready && (exp_cnt >= BURST_LEN || (flush && exp_cnt > 0)))
            begin
                rd_rem   = (exp_cnt < BURST_LEN) ? exp_cnt : BURST_LEN;
                beat_idx = 0;
            end
            if (wr_now)
                exp_q.push_back(wr_data);
            if (wr_now)
                exp_cnt++;
            if (rd_now)
                exp_cnt--;
        end
    end

    //******************************
    // stimulus helpers
    //******************************
    task automatic step();
        @(posedge rclk);
        #2;
    endtask

    task automatic write_word(input logic [DATA_WIDTH-1:0] d);
        wr_en   = 1'b1;
        wr_data = d;
        step();
        wr_en   = 1'b0;
    endtask

    task automatic begin_test(input string name);
        cur_test     = name;
        err_at_start = err_cnt;
        beat_seen    = 0;
        last_seen    = 0;
    endtask

    task automatic end_test();
        test_cnt++;
        $display("test %s finished, %0d errors", cur_test, err_cnt - err_at_start);
    endtask

    // main sequence
    initial
    begin
        void'($urandom(45));
        rrst      = 1'b1;
        wr_en     = 1'b0;
        wr_data   = '0;
        ddr_ready = 1'b0;
        flush     = 1'b0;
        err_cnt   = 0;
        check_cnt = 0;
        test_cnt  = 0;
        repeat (16) @(posedge rclk);
        #2 rrst = 1'b0;

        begin_test("reset_state");
        check_value("rempty", 1, 32'(rempty));
        check_value("almost_empty", 1, 32'(almost_empty));
        check_value("wfull", 0, 32'(wfull));
        check_value("almost_full", 0, 32'(almost_full));
        check_value("ddr_wvalid", 0, 32'(ddr_wvalid));
        check_value("ddr_wfirst", 0, 32'(ddr_wfirst));
        check_value("ddr_wlast", 0, 32'(ddr_wlast));
        check_value("wr_level", 0, 32'(wr_level));
        end_test();

        begin_test("fill");  // last four writes land on a full fifo
        for (int i = 0; i < 20; i++)
            write_word(32'hc0de_0000 | 32'(i));
        check_value("wr_level", DEPTH, 32'(wr_level));
        check_value("wfull", 1, 32'(wfull));
        check_value("almost_full", 1, 32'(almost_full));
        check_value("beats", 0, beat_seen);
        end_test();

        begin_test("drain");
        ddr_ready = 1'b1;
        while (!(wr_level == '0 && !ddr_wvalid))
            step();
        check_value("beats", DEPTH, beat_seen);
        check_value("bursts", DEPTH / BURST_LEN, last_seen);
        end_test();

        begin_test("hold");  // below burst length and no flush
        for (int i = 0; i < 3; i++)
            write_word(32'h0bad_0000 | 32'(i));
        repeat (10) step();
        check_value("beats", 0, beat_seen);
        check_value("almost_empty", 0, 32'(almost_empty));
        check_value("wr_level", 3, 32'(wr_level));
        end_test();

        begin_test("flush");
        flush = 1'b1;
        step();
        flush = 1'b0;
        while (last_seen == 0)
            step();
        check_value("beats", 3, beat_seen);
        check_value("rempty", 1, 32'(rempty));
        end_test();

        begin_test("random");
        for (int i = 0; i < 600; i++)
        begin
            wr_en     = 1'($urandom % 2);
            wr_data   = $urandom;
            ddr_ready = (($urandom % 4) != 0);
            flush     = (($urandom % 16) == 0);
            step();
        end
        // drain the leftovers so every stored word comes out
        wr_en     = 1'b0;
        flush     = 1'b1;
        ddr_ready = 1'b1;
        while (!(rempty && !ddr_wvalid))
            step();
        flush     = 1'b0;
        end_test();

        $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    // cycle limit
    initial
    begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYC)
        begin
            @(posedge rclk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, test %s did not finish", cycle_cnt, cur_test);
        $display("Errors found");
        $finish;
    end

endmodule

// File: list.f
ddr_wbuf_pkg.sv
fifo_mem_if.sv
wbuf_fifo_ctrl.sv
wbuf_ram.sv
burst_reader.sv
ddr_wbuf_top.sv
tb_ddr_wbuf.sv

// File: Makefile
# Verilator build for the ddr3 write-data buffer testbench

TOP = tb_ddr_wbuf

.PHONY: all compile run clean

all: run

# build the simulation executable into obj_dir
compile:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)

# run and decide pass or fail from the printed output
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -q "^No errors$$"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf obj_dir
